// ==== src/sram_bist_pkg.sv ====
package sram_bist_pkg;

  // sram geometry
  localparam int ADDR_BITS = 4;
  localparam int DATA_BITS = 8;
  localparam int NUM_WORDS = 2 ** ADDR_BITS;

  // test patterns, run in this order each round
  typedef enum logic [2:0] {
    PAT_ZEROS,
    PAT_ONES,
    PAT_55,
    PAT_AA,
    PAT_ADDR
  } pattern_e;

  typedef enum logic {
    PH_WRITE,
    PH_READ
  } tester_phase_e;

  typedef enum logic [2:0] {
    IDLE,
    WR_PULSE,
    WR_END,
    RD_PULSE,
    RD_END
  } ctrl_state_e;

  typedef struct packed {
    logic                 we;
    logic [ADDR_BITS-1:0] addr;
    logic [DATA_BITS-1:0] wdata;
  } mem_req_t;

  typedef struct packed {
    logic [ADDR_BITS-1:0] addr;
    logic [DATA_BITS-1:0] dout;
    logic                 dout_en;
    logic                 ce_n;
    logic                 oe_n;
    logic                 we_n;
  } sram_pins_t;

  typedef struct packed {
    pattern_e             pattern;
    tester_phase_e        phase;
    logic [ADDR_BITS-1:0] addr;
    logic                 done;
    logic                 pass;
    logic [DATA_BITS-1:0] err_expected;
    logic [DATA_BITS-1:0] err_read;
  } tester_status_t;

  // data word written to / expected from a given address
  function automatic logic [DATA_BITS-1:0] pattern_data(pattern_e pat,
                                                         logic [ADDR_BITS-1:0] addr);
    logic [DATA_BITS-1:0] data;
    case (pat)
      PAT_ZEROS: data = '0;
      PAT_ONES:  data = '1;
      PAT_55:    data = DATA_BITS'(8'h55);
      PAT_AA:    data = DATA_BITS'(8'hAA);
      PAT_ADDR:  data = DATA_BITS'(addr) + DATA_BITS'(8'h30);
      default:   data = '0;
    endcase
    return data;
  endfunction

endpackage

// ==== src/sram_access_ctrl.sv ====
module sram_access_ctrl
  import sram_bist_pkg::*;
(
  input  logic                 CLK,
  input  logic                 arst_n,
  input  logic                 req_valid,
  input  mem_req_t             req,
  input  logic [DATA_BITS-1:0] sram_din,
  output logic                 done,
  output logic [DATA_BITS-1:0] rdata,
  output sram_pins_t           pins
);

  ctrl_state_e state;

  // strobes, all active low except dout_en
  logic ce_n;
  logic oe_n;
  logic we_n;
  logic dout_en;

  // address and write data held for the whole access
  logic [ADDR_BITS-1:0] addr_q;
  logic [DATA_BITS-1:0] dout_q;

  logic accept;

  assign accept = (state == IDLE) && req_valid;

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      state   <= IDLE;
      done    <= 1'b0;
      ce_n    <= 1'b1;
      oe_n    <= 1'b1;
      we_n    <= 1'b1;
      dout_en <= 1'b0;
    end else begin
      done <= 1'b0;
      case (state)
        IDLE: begin
          if (req_valid) begin
            ce_n <= 1'b0;
            if (req.we) begin
              we_n    <= 1'b0;
              dout_en <= 1'b1;
              state   <= WR_PULSE;
            end else begin
              oe_n  <= 1'b0;
              state <= RD_PULSE;
            end
          end
        end
        // we_n rises here, addr and data stay put one more cycle
        WR_PULSE: begin
          we_n  <= 1'b1;
          done  <= 1'b1;
          state <= WR_END;
        end
        WR_END: begin
          ce_n    <= 1'b1;
          dout_en <= 1'b0;
          state   <= IDLE;
        end
        RD_PULSE: state <= RD_END;
        // end of the oe window, done follows with the captured word
        RD_END: begin
          ce_n  <= 1'b1;
          oe_n  <= 1'b1;
          done  <= 1'b1;
          state <= IDLE;
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge CLK) begin
    if (accept) begin
      addr_q <= req.addr;
      dout_q <= req.wdata;
    end
    if (state == RD_END) begin
      rdata <= sram_din;
    end
  end

  assign pins = '{addr: addr_q, dout: dout_q, dout_en: dout_en,
                  ce_n: ce_n, oe_n: oe_n, we_n: we_n};

endmodule

// ==== src/sram_pattern_tester.sv ====
module sram_pattern_tester
  import sram_bist_pkg::*;
(
  input  logic                 CLK,
  input  logic                 arst_n,
  input  logic                 done,
  input  logic [DATA_BITS-1:0] rdata,
  output logic                 req_valid,
  output mem_req_t             req,
  output tester_status_t       status,
  output logic [DATA_BITS-1:0] cur_wdata
);

  pattern_e             pattern;
  tester_phase_e        phase;
  logic [ADDR_BITS-1:0] addr;

  logic                 busy;
  logic                 waiting;
  logic                 last_addr;
  logic                 round_end;
  logic                 round_done;
  logic                 mismatch;
  logic                 round_ok;
  logic                 fail_seen;
  logic                 pass;
  logic [DATA_BITS-1:0] expected;
  logic [DATA_BITS-1:0] err_expected;
  logic [DATA_BITS-1:0] err_read;

  // pattern word for the current address, written or compared
  assign expected  = pattern_data(pattern, addr);
  assign cur_wdata = expected;

  assign req = '{we: (phase == PH_WRITE), addr: addr, wdata: expected};

  // an access is in flight and has not finished this cycle
  assign waiting   = busy && !done;
  assign last_addr = (addr == ADDR_BITS'(NUM_WORDS - 1));
  assign round_end = done && last_addr && (phase == PH_READ) && (pattern == PAT_ADDR);
  assign mismatch  = done && (phase == PH_READ) && (rdata != expected);

  // one request at a time, reissued right after done
  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      busy      <= 1'b0;
      req_valid <= 1'b0;
    end else begin
      req_valid <= 1'b0;
      if (!waiting) begin
        req_valid <= 1'b1;
        busy      <= 1'b1;
      end
    end
  end

  // address / phase / pattern sequencer
  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      pattern    <= PAT_ZEROS;
      phase      <= PH_WRITE;
      addr       <= '0;
      round_done <= 1'b0;
    end else begin
      round_done <= round_end;
      if (done) begin
        if (last_addr) begin
          addr <= '0;
          if (phase == PH_WRITE) begin
            phase <= PH_READ;
          end else begin
            phase <= PH_WRITE;
            if (pattern == PAT_ADDR) begin
              pattern <= PAT_ZEROS;
            end else begin
              pattern <= pattern_e'(pattern + 3'd1);
            end
          end
        end else begin
          addr <= addr + 1'b1;
        end
      end
    end
  end

  // compare results, pass is sticky low after any failure
  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      round_ok     <= 1'b1;
      fail_seen    <= 1'b0;
      pass         <= 1'b0;
      err_expected <= '0;
      err_read     <= '0;
    end else begin
      if (mismatch) begin
        round_ok  <= 1'b0;
        fail_seen <= 1'b1;
        pass      <= 1'b0;
        // keep the first failure since reset
        if (!fail_seen) begin
          err_expected <= expected;
          err_read     <= rdata;
        end
      end
      if (round_end) begin
        round_ok <= 1'b1;
        pass     <= round_ok && !mismatch && !fail_seen;
      end
    end
  end

  assign status = '{pattern: pattern, phase: phase, addr: addr, done: round_done,
                    pass: pass, err_expected: err_expected, err_read: err_read};

endmodule

// ==== src/debug_display_map.sv ====
module debug_display_map
  import sram_bist_pkg::*;
(
  input  tester_status_t       status,
  input  logic [DATA_BITS-1:0] cur_wdata,
  input  logic [DATA_BITS-1:0] cur_rdata,
  output logic                 led_done,
  output logic                 led_pass,
  output logic [7:0]           dbg_e,
  output logic [7:0]           dbg_f,
  output logic [7:0]           dbg_h,
  output logic [7:0]           dbg_i,
  output logic [7:0]           dbg_j
);

  logic [2:0]           pat_bits;
  logic [2:0]           pat_rev;
  logic [ADDR_BITS-1:0] addr_rev;

  assign pat_bits = status.pattern;

  // msb-first wiring on the debug headers
  always_comb begin
    for (int i = 0; i < ADDR_BITS; i++) begin
      addr_rev[i] = status.addr[ADDR_BITS-1-i];
    end
    for (int i = 0; i < 3; i++) begin
      pat_rev[i] = pat_bits[2-i];
    end
  end

  assign led_done = status.done;
  assign led_pass = status.pass;

  // upper nibble unused with a 4-bit address
  assign dbg_e = {4'b0000, 1'b0, pat_rev};
  assign dbg_f = 8'(addr_rev[ADDR_BITS-1:ADDR_BITS/2]);
  assign dbg_h = 8'(addr_rev[ADDR_BITS/2-1:0]);

  // live data while passing, else the captured mismatch
  assign dbg_i = status.pass ? 8'(cur_wdata) : 8'(status.err_expected);
  assign dbg_j = status.pass ? 8'(cur_rdata) : 8'(status.err_read);

endmodule

// ==== src/sram_bist_top.sv ====
module sram_bist_top
  import sram_bist_pkg::*;
(
  input  logic                 CLK,
  input  logic                 arst_n,
  input  logic [DATA_BITS-1:0] sram_din,
  output logic [ADDR_BITS-1:0] sram_addr,
  output logic [DATA_BITS-1:0] sram_dout,
  output logic                 sram_dout_en,
  output logic                 sram_ce_n,
  output logic                 sram_oe_n,
  output logic                 sram_we_n,
  output logic                 led_done,
  output logic                 led_pass,
  output logic [7:0]           dbg_e,
  output logic [7:0]           dbg_f,
  output logic [7:0]           dbg_h,
  output logic [7:0]           dbg_i,
  output logic [7:0]           dbg_j
);

  logic                 req_valid;
  mem_req_t             req;
  logic                 done;
  logic [DATA_BITS-1:0] rdata;
  logic [DATA_BITS-1:0] cur_wdata;
  sram_pins_t           pins;
  tester_status_t       status;

  sram_pattern_tester i_tester (
    .CLK       (CLK),
    .arst_n    (arst_n),
    .done      (done),
    .rdata     (rdata),
    .req_valid (req_valid),
    .req       (req),
    .status    (status),
    .cur_wdata (cur_wdata)
  );

  sram_access_ctrl i_ctrl (
    .CLK       (CLK),
    .arst_n    (arst_n),
    .req_valid (req_valid),
    .req       (req),
    .sram_din  (sram_din),
    .done      (done),
    .rdata     (rdata),
    .pins      (pins)
  );

  debug_display_map i_dbg (
    .status    (status),
    .cur_wdata (cur_wdata),
    .cur_rdata (rdata),
    .led_done  (led_done),
    .led_pass  (led_pass),
    .dbg_e     (dbg_e),
    .dbg_f     (dbg_f),
    .dbg_h     (dbg_h),
    .dbg_i     (dbg_i),
    .dbg_j     (dbg_j)
  );

  // pin bundle out to the board
  assign sram_addr    = pins.addr;
  assign sram_dout    = pins.dout;
  assign sram_dout_en = pins.dout_en;
  assign sram_ce_n    = pins.ce_n;
  assign sram_oe_n    = pins.oe_n;
  assign sram_we_n    = pins.we_n;

endmodule

// ==== test/sram_model.sv ====
module sram_model
  import sram_bist_pkg::*;
(
  input  logic [ADDR_BITS-1:0]         addr,
  input  logic [DATA_BITS-1:0]         dout,
  input  logic                         dout_en,
  input  logic                         ce_n,
  input  logic                         oe_n,
  input  logic                         we_n,
  input  logic                         fault_en,
  input  logic [ADDR_BITS-1:0]         fault_addr,
  input  logic [$clog2(DATA_BITS)-1:0] fault_bit,
  output logic [DATA_BITS-1:0]         din
);

  logic [DATA_BITS-1:0] mem [NUM_WORDS];
  logic [DATA_BITS-1:0] word;

  // power-up contents differ in every word
  initial begin
    for (int i = 0; i < NUM_WORDS; i++) begin
      mem[i] = DATA_BITS'(8'hc3 ^ (i * 37));
    end
  end

  // the write lands when we_n rises
  always @(posedge we_n) begin
    if (!ce_n && dout_en) begin
      mem[addr] <= dout;
    end
  end

  // asynchronous read with a stuck-at-1 bit on the faulty word
  always_comb begin
    word = mem[addr];
    if (fault_en && (addr == fault_addr)) begin
      word[fault_bit] = 1'b1;
    end
    // bus floats high with no chip driving it
    din = (!ce_n && !oe_n) ? word : '1;
  end

endmodule

// ==== test/sram_bist_checker.sv ====
module sram_bist_checker (
  input logic CLK,
  input logic arst_n,
  input logic req_valid,
  input logic ce_n,
  input logic oe_n,
  input logic we_n,
  input logic dout_en
);

  logic req_seen;

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      req_seen <= 1'b0;
    end else if (req_valid) begin
      req_seen <= 1'b1;
    end
  end

  a_no_bus_fight: assert property (@(posedge CLK) disable iff (!arst_n)
    !(!oe_n && !we_n))
    else $error("oe_n and we_n low in the same cycle");

  a_we_needs_ce: assert property (@(posedge CLK) disable iff (!arst_n)
    !we_n |-> !ce_n)
    else $error("we_n low while ce_n is high");

  // data must be on the bus for the whole write pulse
  a_we_needs_dout: assert property (@(posedge CLK) disable iff (!arst_n)
    !we_n |-> dout_en)
    else $error("we_n low without dout_en");

  a_idle_until_req: assert property (@(posedge CLK) disable iff (!arst_n)
    !req_seen |-> (ce_n && oe_n && we_n))
    else $error("sram strobe active before the first request");

endmodule

// ==== test/sram_bist_tb.sv ====
module sram_bist_tb
  import sram_bist_pkg::*;
();

  localparam int CLK_PERIOD      = 8;
  localparam int RESET_CYCLES    = 16;
  // 5 patterns x 16 words x (3 write + 4 read cycles)
  localparam int ROUND_CYCLES    = 5 * NUM_WORDS * 7;
  localparam int WAIT_LIMIT      = ROUND_CYCLES + 40;
  localparam int WATCHDOG_CYCLES = 4 * ROUND_CYCLES + 2 * RESET_CYCLES + 200;

  logic                 CLK = 1'b1;
  logic                 arst_n;
  logic [DATA_BITS-1:0] sram_din;
  logic [ADDR_BITS-1:0] sram_addr;
  logic [DATA_BITS-1:0] sram_dout;
  logic                 sram_dout_en;
  logic                 sram_ce_n;
  logic                 sram_oe_n;
  logic                 sram_we_n;
  logic                 led_done;
  logic                 led_pass;
  logic [7:0]           dbg_e;
  logic [7:0]           dbg_f;
  logic [7:0]           dbg_h;
  logic [7:0]           dbg_i;
  logic [7:0]           dbg_j;
  logic                 fault_en;
  logic [ADDR_BITS-1:0] fault_addr;
  logic [2:0]           fault_bit;

  // scoreboard of completed writes
  logic [ADDR_BITS-1:0] wr_addr_q[$];
  logic [DATA_BITS-1:0] wr_data_q[$];

  sram_bist_top i_dut (.*);

  sram_model i_sram (
    .addr       (sram_addr),
    .dout       (sram_dout),
    .dout_en    (sram_dout_en),
    .ce_n       (sram_ce_n),
    .oe_n       (sram_oe_n),
    .we_n       (sram_we_n),
    .fault_en   (fault_en),
    .fault_addr (fault_addr),
    .fault_bit  (fault_bit),
    .din        (sram_din)
  );

  bind sram_bist_top sram_bist_checker i_checker (
    .CLK       (CLK),
    .arst_n    (arst_n),
    .req_valid (req_valid),
    .ce_n      (sram_ce_n),
    .oe_n      (sram_oe_n),
    .we_n      (sram_we_n),
    .dout_en   (sram_dout_en)
  );

  always #(CLK_PERIOD / 2) CLK = ~CLK;

  always @(posedge sram_we_n) begin
    if (arst_n && !sram_ce_n) begin
      wr_addr_q.push_back(sram_addr);
      wr_data_q.push_back(sram_dout);
    end
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("run timed out after %0d cycles", WATCHDOG_CYCLES);
    $display("tests failed");
    $fatal(1, "watchdog expired");
  end

  function automatic logic [7:0] expected_word(int pat, int a);
    case (pat)
      0: return 8'h00;
      1: return 8'hff;
      2: return 8'h55;
      3: return 8'haa;
      default: return 8'(a + 'h30);
    endcase
  endfunction

  // pattern index recovered from the word on the bus
  function automatic int pattern_of_word(logic [7:0] w);
    case (w)
      8'h00: return 0;
      8'hff: return 1;
      8'h55: return 2;
      8'haa: return 3;
      default: return 4;
    endcase
  endfunction

  function automatic logic [7:0] reverse_bits(logic [7:0] v, int width);
    logic [7:0] r;
    r = '0;
    for (int i = 0; i < width; i++) begin
      r[i] = v[width-1-i];
    end
    return r;
  endfunction

  task automatic check_value(string name, logic [31:0] got, logic [31:0] expected);
    if (got !== expected) begin
      $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, expected);
      $display("tests failed");
      $fatal(1, "stopping at the first error");
    end
  endtask

  task automatic report_timeout(string what);
    $display("timed out waiting for %s", what);
    $display("tests failed");
    $fatal(1, "wait limit exceeded");
  endtask

  task automatic check_idle_outputs();
    check_value("sram_ce_n", sram_ce_n, 1);
    check_value("sram_oe_n", sram_oe_n, 1);
    check_value("sram_we_n", sram_we_n, 1);
    check_value("led_done", led_done, 0);
    check_value("led_pass", led_pass, 0);
    check_value("sram_dout_en", sram_dout_en, 0);
    check_value("dbg_i", dbg_i, 0);
  endtask

  task automatic reset_dut(bit check_idle);
    @(negedge CLK);
    arst_n = 1'b0;
    wr_addr_q.delete();
    wr_data_q.delete();
    for (int i = 0; i < RESET_CYCLES; i++) begin
      @(negedge CLK);
      if (check_idle) begin
        check_idle_outputs();
      end
    end
    arst_n = 1'b1;
  endtask

  // returns on the falling edge that sees the end-of-round pulse
  task automatic wait_led_done();
    int cycles;
    cycles = 0;
    @(negedge CLK);
    while (led_done !== 1'b1) begin
      cycles++;
      if (cycles > WAIT_LIMIT) begin
        report_timeout("led_done");
      end
      @(negedge CLK);
    end
  endtask

  task automatic test_reset_state();
    reset_dut(1'b1);
    check_idle_outputs();
    @(negedge CLK);
    check_idle_outputs();
  endtask

  task automatic test_clean_round();
    wait_led_done();
    check_value("led_pass", led_pass, 1);
    check_value("write count", wr_addr_q.size(), 5 * NUM_WORDS);
    for (int i = 0; i < 5 * NUM_WORDS; i++) begin
      check_value("write addr", wr_addr_q[i], i % NUM_WORDS);
      check_value("write data", wr_data_q[i], expected_word(i / NUM_WORDS, i % NUM_WORDS));
    end
    @(negedge CLK);
    check_value("led_done", led_done, 0);
    check_value("led_pass", led_pass, 1);
  endtask

  task automatic test_debug_mapping();
    logic [7:0] rev;
    int cycles;
    int writes;
    cycles = 0;
    writes = 0;
    while (led_done !== 1'b1) begin
      check_value("led_pass", led_pass, 1);
      if (!sram_ce_n) begin
        rev = reverse_bits(8'(sram_addr), ADDR_BITS);
        check_value("dbg_f", dbg_f, rev[ADDR_BITS-1:ADDR_BITS/2]);
        check_value("dbg_h", dbg_h, rev[ADDR_BITS/2-1:0]);
        if (sram_dout_en) begin
          writes++;
          check_value("dbg_e", dbg_e, reverse_bits(8'(pattern_of_word(sram_dout)), 3));
          check_value("dbg_i", dbg_i, sram_dout);
        end
      end
      cycles++;
      if (cycles > WAIT_LIMIT) begin
        report_timeout("the end of the debug round");
      end
      @(negedge CLK);
    end
    check_value("sampled write cycles", writes != 0, 1);
  endtask

  task automatic test_fault_detection();
    reset_dut(1'b0);
    fault_en   = 1'b1;
    fault_addr = 4'd5;
    fault_bit  = 3'd0;
    wait_led_done();
    check_value("led_pass", led_pass, 0);
    check_value("dbg_i", dbg_i, 8'h00);
    check_value("dbg_j", dbg_j, 8'h01);
  endtask

  task automatic test_sticky_failure();
    @(negedge CLK);
    fault_en = 1'b0;
    wait_led_done();
    check_value("led_pass", led_pass, 0);
    check_value("dbg_i", dbg_i, 8'h00);
    check_value("dbg_j", dbg_j, 8'h01);
  endtask

  initial begin
    arst_n     = 1'b1;
    fault_en   = 1'b0;
    fault_addr = '0;
    fault_bit  = '0;
    test_reset_state();
    test_clean_round();
    test_debug_mapping();
    test_fault_detection();
    test_sticky_failure();
    $display("all tests passed");
    $finish;
  end

endmodule

// ==== filelist.f ====
src/sram_bist_pkg.sv
src/sram_access_ctrl.sv
src/sram_pattern_tester.sv
src/debug_display_map.sv
src/sram_bist_top.sv
test/sram_model.sv
test/sram_bist_checker.sv
test/sram_bist_tb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal --top-module sram_bist_tb -f filelist.f; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vsram_bist_tb 2>&1)
status=$?
echo "$out"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "all tests passed"; then
  exit 0
fi
echo "pass message not found in simulation output"
exit 1
